// File: common/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

  // ########################################
  // default sizes for the top level
  // ########################################
  localparam int DEF_DATA_WIDTH  = 8;
  localparam int DEF_FIFO_DEPTH  = 16;
  localparam int DEF_FIFO_AFULL  = 12;
  localparam int DEF_FIFO_AEMPTY = 2;

  // log2 of a power-of-two depth
  function automatic int addr_bits(input int depth);
    int bits;
    bits = 0;
    for (int i = 0; i < 31; i++) begin
      if ((1 << i) < depth) begin
        bits = i + 1;
      end
    end
    return bits;
  endfunction

endpackage

// File: common/gray_pkg.sv
package gray_pkg;

  // ########################################
  // gray code conversion, 32 bit wide
  // ########################################

  // callers keep only the low pointer bits
  function automatic logic [31:0] bin2gray(input logic [31:0] bin);
    logic [31:0] gray;
    gray = bin ^ (bin >> 1);
    return gray;
  endfunction

  // prefix xor, msb first
  function automatic logic [31:0] gray2bin(input logic [31:0] gray);
    logic [31:0] bin;
    bin[31] = gray[31];
    for (int i = 30; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: common/fifo_ram_if.sv
`timescale 1ns/1ps

interface fifo_ram_if import fifo_cfg_pkg::*; #(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = addr_bits(DEF_FIFO_DEPTH)
);

  // write port, wr_clk domain
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;

  // read port, rd_clk domain
  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] rd_data;

  modport wr_side (output wr_en, output wr_addr);

  modport rd_side (output rd_en, output rd_addr);

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// File: async_fifo/fifo_ram.sv
`timescale 1ns/1ps

module fifo_ram (
  fifo_ram_if.mem ram,
  input  logic    wr_clk,
  input  logic    rd_clk,
  input  logic    rd_rst_n
);

  // sizes come from the interface the top level built
  localparam int DW = $bits(ram.wr_data);
  localparam int AW = $bits(ram.wr_addr);

  logic [DW-1:0] mem [2**AW];

  // ########################################
  // write port
  // ########################################
  always_ff @(posedge wr_clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // ########################################
  // registered read port
  // ########################################

  // holds the last word until the next read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      ram.rd_data <= '0;
    end else if (ram.rd_en) begin
      ram.rd_data <= mem[ram.rd_addr];
    end
  end

endmodule

// File: async_fifo/fifo_wr_ctrl.sv
`timescale 1ns/1ps

module fifo_wr_ctrl import fifo_cfg_pkg::*; import gray_pkg::*; #(
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL = DEF_FIFO_AFULL,
  localparam int PW        = addr_bits(FIFO_DEPTH) + 1
) (
  input  logic          wr_clk,
  input  logic          wr_rst_n,
  input  logic          wr_en,
  input  logic [PW-1:0] rd_ptr_gray,
  output logic [PW-1:0] wr_ptr_gray,
  output logic          full,
  output logic          afull,
  fifo_ram_if.wr_side   ram
);

  logic          wr_fire;
  logic [PW-1:0] wr_bin;
  logic [PW-1:0] wr_bin_nxt;
  logic [PW-1:0] wr_gray_nxt;
  logic [PW-1:0] rd_sync1;
  logic [PW-1:0] rd_sync2;
  logic [PW-1:0] rd_bin_sync;
  logic [PW-1:0] wr_count;
  logic          full_nxt;
  logic          afull_nxt;

  // ########################################
  // write pointer
  // ########################################
  assign wr_fire     = wr_en & ~full;
  assign wr_bin_nxt  = wr_bin + PW'(wr_fire);
  assign wr_gray_nxt = PW'(bin2gray(32'(wr_bin_nxt)));

  assign ram.wr_en   = wr_fire;
  assign ram.wr_addr = wr_bin[PW-2:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_bin      <= wr_bin_nxt;
      wr_ptr_gray <= wr_gray_nxt;
    end
  end

  // ########################################
  // read pointer into wr_clk domain
  // ########################################
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_sync1 <= '0;
      rd_sync2 <= '0;
    end else begin
      rd_sync1 <= rd_ptr_gray;
      rd_sync2 <= rd_sync1;
    end
  end

  assign rd_bin_sync = PW'(gray2bin(32'(rd_sync2)));

  // full when a lap ahead: top two gray bits inverted
  assign full_nxt  = wr_gray_nxt == {~rd_sync2[PW-1:PW-2], rd_sync2[PW-3:0]};
  assign wr_count  = wr_bin_nxt - rd_bin_sync;
  assign afull_nxt = wr_count >= FIFO_AFULL;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

  // write pointer never gets more than one lap ahead of the read pointer
  a_no_overflow: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) wr_count <= FIFO_DEPTH);

  a_wr_gray_one_bit: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1);

endmodule

// File: async_fifo/fifo_rd_ctrl.sv
`timescale 1ns/1ps

module fifo_rd_ctrl import fifo_cfg_pkg::*; import gray_pkg::*; #(
  parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH,
  parameter int FIFO_AEMPTY = DEF_FIFO_AEMPTY,
  localparam int PW         = addr_bits(FIFO_DEPTH) + 1
) (
  input  logic          rd_clk,
  input  logic          rd_rst_n,
  input  logic          rd_en,
  input  logic [PW-1:0] wr_ptr_gray,
  output logic [PW-1:0] rd_ptr_gray,
  output logic          empty,
  output logic          aempty,
  fifo_ram_if.rd_side   ram
);

  logic          rd_fire;
  logic [PW-1:0] rd_bin;
  logic [PW-1:0] rd_bin_nxt;
  logic [PW-1:0] rd_gray_nxt;
  logic [PW-1:0] wr_sync1;
  logic [PW-1:0] wr_sync2;
  logic [PW-1:0] wr_bin_sync;
  logic [PW-1:0] rd_count;
  logic          empty_nxt;
  logic          aempty_nxt;

  // ########################################
  // read pointer
  // ########################################
  assign rd_fire     = rd_en & ~empty;
  assign rd_bin_nxt  = rd_bin + PW'(rd_fire);
  assign rd_gray_nxt = PW'(bin2gray(32'(rd_bin_nxt)));

  assign ram.rd_en   = rd_fire;
  assign ram.rd_addr = rd_bin[PW-2:0];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_bin      <= rd_bin_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // ########################################
  // write pointer into rd_clk domain
  // ########################################
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_sync1 <= '0;
      wr_sync2 <= '0;
    end else begin
      wr_sync1 <= wr_ptr_gray;
      wr_sync2 <= wr_sync1;
    end
  end

  assign wr_bin_sync = PW'(gray2bin(32'(wr_sync2)));

  // empty once the next read pointer catches the synced write pointer
  assign empty_nxt  = rd_gray_nxt == wr_sync2;
  assign rd_count   = wr_bin_sync - rd_bin_nxt;
  assign aempty_nxt = rd_count <= FIFO_AEMPTY;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

  // read pointer never passes the synced write pointer
  a_no_underflow: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) rd_count <= FIFO_DEPTH);

  a_rd_gray_one_bit: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1);

endmodule

// File: source/async_fifo_top.sv
`timescale 1ns/1ps

module async_fifo_top import fifo_cfg_pkg::*; #(
  parameter int DATA_WIDTH  = DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL  = DEF_FIFO_AFULL,
  parameter int FIFO_AEMPTY = DEF_FIFO_AEMPTY
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  empty,
  output logic                  afull,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = addr_bits(FIFO_DEPTH);

  // gray pointers crossing between the clock domains
  logic [ADDR_WIDTH:0] wr_ptr_gray;
  logic [ADDR_WIDTH:0] rd_ptr_gray;

  fifo_ram_if #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ram_if ();

  assign ram_if.wr_data = wr_data;
  assign rd_data        = ram_if.rd_data;

  fifo_ram u_ram (
    .ram      (ram_if.mem),
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n)
  );

  fifo_wr_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull),
    .ram         (ram_if.wr_side)
  );

  fifo_rd_ctrl #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty),
    .ram         (ram_if.rd_side)
  );

endmodule

// File: sim/tb_async_fifo.sv
`timescale 1ns/1ps

module tb_async_fifo import fifo_cfg_pkg::*; ();

  localparam int DW    = DEF_DATA_WIDTH;
  localparam int DEPTH = DEF_FIFO_DEPTH;

  logic          wr_clk = 1'b0;
  logic          rd_clk = 1'b0;
  logic          wr_rst_n;
  logic          rd_rst_n;
  logic          wr_en;
  logic          rd_en;
  logic [DW-1:0] wr_data;
  logic [DW-1:0] rd_data;
  logic          full;
  logic          empty;
  logic          afull;
  logic          aempty;

  logic [15:0]   lfsr = 16'd25150;
  logic [DW-1:0] model [$];
  logic [DW-1:0] rd_expect;
  logic          rd_pending = 1'b0;
  logic          rd_bits [400];
  int            reads_done = 0;
  int            errors = 0;
  int            pass_count = 0;
  int            fail_count = 0;
  string         cur_test = "reset";

  always #14 wr_clk = ~wr_clk;
  always #20 rd_clk = ~rd_clk;

  async_fifo_top u_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("test %s went wrong: %s", cur_test, msg);
    errors++;
  endtask

  task automatic end_test(input int errs_before);
    if (errors == errs_before) begin
      pass_count++;
      $display("test %s: ok", cur_test);
    end else begin
      fail_count++;
      $display("test %s: failed", cur_test);
    end
  endtask

  // ########################################
  // reference model
  // ########################################
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model.push_back(wr_data);
      if (model.size() > DEPTH) report_fail("model holds more words than the FIFO depth");
    end
  end

  // popped word shows on rd_data one cycle later
  always @(posedge rd_clk) begin
    if (rd_pending) begin
      check_val({cur_test, " read data"}, rd_expect, rd_data);
      rd_pending = 1'b0;
    end
    if (rd_rst_n && rd_en && !empty) begin
      if (model.size() == 0) begin
        report_fail("a read was accepted while the model was empty");
      end else begin
        rd_expect  = model.pop_front();
        rd_pending = 1'b1;
        reads_done++;
      end
    end
  end

  task automatic wait_empty();
    int guard;
    guard = 0;
    @(negedge rd_clk);
    while (!empty && guard < 50) begin
      @(negedge rd_clk);
      guard++;
    end
    if (!empty) report_fail("timed out waiting for empty");
  endtask

  task automatic drain_fifo();
    int guard;
    guard = 0;
    @(posedge rd_clk);
    rd_en <= 1'b1;
    @(negedge rd_clk);
    while ((model.size() != 0 || rd_pending) && guard < 400) begin
      @(negedge rd_clk);
      guard++;
    end
    if (model.size() != 0 || rd_pending) report_fail("timed out draining the FIFO");
    @(posedge rd_clk);
    rd_en <= 1'b0;
  endtask

  // ########################################
  // test sequence
  // ########################################
  initial begin
    int            e0;
    int            n_before;
    int            guard;
    logic          done;
    logic [DW-1:0] held;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    repeat (2) @(posedge rd_clk);
    wr_rst_n <= 1'b1;
    rd_rst_n <= 1'b1;

    e0 = errors;
    @(negedge rd_clk);
    check_val("reset empty", 1, empty);
    check_val("reset aempty", 1, aempty);
    check_val("reset full", 0, full);
    check_val("reset afull", 0, afull);
    end_test(e0);

    // full must rise with the DEPTH-th accepted write
    cur_test = "fill";
    e0       = errors;
    guard    = 0;
    done     = 1'b0;
    @(posedge wr_clk);
    wr_en   <= 1'b1;
    wr_data <= DW'(rand_bits(DW));
    while (!done) begin
      @(negedge wr_clk);
      check_val("fill full flag", model.size() == DEPTH, full);
      guard++;
      if (full) begin
        done = 1'b1;
      end else if (guard > 4 * DEPTH) begin
        report_fail("timed out waiting for full");
        done = 1'b1;
      end
      @(posedge wr_clk);
      wr_data <= DW'(rand_bits(DW));
    end
    repeat (4) begin
      @(posedge wr_clk);
      wr_data <= DW'(rand_bits(DW));
    end
    wr_en <= 1'b0;
    @(negedge wr_clk);
    check_val("fill word count", DEPTH, model.size());
    check_val("fill full held", 1, full);
    end_test(e0);

    cur_test = "drain";
    e0       = errors;
    n_before = reads_done;
    drain_fifo();
    check_val("drain word count", DEPTH, reads_done - n_before);
    wait_empty();
    held = rd_data;
    @(posedge rd_clk);
    rd_en <= 1'b1;
    repeat (4) @(negedge rd_clk);
    check_val("drain read while empty", held, rd_data);
    @(posedge rd_clk);
    rd_en <= 1'b0;
    end_test(e0);

    cur_test = "thresholds";
    e0       = errors;
    for (int n = 0; n <= DEPTH; n++) begin
      for (int i = 0; i < n; i++) begin
        @(posedge wr_clk);
        wr_en   <= 1'b1;
        wr_data <= DW'(rand_bits(DW));
      end
      @(posedge wr_clk);
      wr_en <= 1'b0;
      repeat (6) @(posedge wr_clk);
      repeat (6) @(posedge rd_clk);
      @(negedge rd_clk);
      check_val($sformatf("afull n=%0d", n), n >= DEF_FIFO_AFULL, afull);
      check_val($sformatf("aempty n=%0d", n), n <= DEF_FIFO_AEMPTY, aempty);
      drain_fifo();
      wait_empty();
      repeat (4) @(posedge wr_clk);
    end
    end_test(e0);

    // read enables drawn up front so the two domains never race for the lfsr
    cur_test = "random";
    e0       = errors;
    for (int i = 0; i < 400; i++) begin
      rd_bits[i] = rand_bits(1) != 0;
    end
    fork
      begin
        repeat (400) begin
          @(posedge wr_clk);
          wr_en   <= rand_bits(1) != 0;
          wr_data <= DW'(rand_bits(DW));
        end
        @(posedge wr_clk);
        wr_en <= 1'b0;
      end
      begin
        for (int i = 0; i < 400; i++) begin
          @(posedge rd_clk);
          rd_en <= rd_bits[i];
        end
        @(posedge rd_clk);
        rd_en <= 1'b0;
      end
    join
    drain_fifo();
    check_val("random model empty", 0, model.size());
    wait_empty();
    end_test(e0);

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
common/fifo_cfg_pkg.sv
common/gray_pkg.sv
common/fifo_ram_if.sv
async_fifo/fifo_ram.sv
async_fifo/fifo_wr_ctrl.sv
async_fifo/fifo_rd_ctrl.sv
source/async_fifo_top.sv
sim/tb_async_fifo.sv

// File: Bender.yml
package:
  name: async_fifo

sources:
  - common/fifo_cfg_pkg.sv
  - common/gray_pkg.sv
  - common/fifo_ram_if.sv
  - async_fifo/fifo_ram.sv
  - async_fifo/fifo_wr_ctrl.sv
  - async_fifo/fifo_rd_ctrl.sv
  - source/async_fifo_top.sv
  - target: simulation
    files:
      - sim/tb_async_fifo.sv
